// ==== src/exe_pkg.sv ====
package exe_pkg;

    // alu operation select
    typedef enum logic [3:0] {
        op_add,
        op_addu,
        op_sub,
        op_subu,
        op_and,
        op_or,
        op_xor,
        op_nor,
        op_slt,
        op_sltu,
        op_sll,
        op_srl,
        op_sra,
        op_lui,
        op_div,
        op_divu
    } op_t;

    typedef enum logic [3:0] {
        mem_none,
        mem_lb,
        mem_lbu,
        mem_lh,
        mem_lhu,
        mem_lw,
        mem_sb,
        mem_sh,
        mem_sw
    } mem_op_t;

    // MIPS cause register codes
    typedef enum logic [4:0] {
        exc_none = 5'd0,
        exc_adel = 5'd4,
        exc_ades = 5'd5,
        exc_ov   = 5'd12
    } exc_t;

    localparam int DMEM_WORDS = 256; // data ram depth in words
    localparam int DMEM_AW    = 8;   // word index, byte address bits 9:2
    localparam int DIV_CYCLES = 33;  // start to done

    typedef struct packed {
        logic [4:0]  dest;
        logic [31:0] result;   // alu result or effective address
        mem_op_t     mem_op;
        logic [1:0]  byte_sel;
        logic [31:0] rdata;    // raw load word
        exc_t        exc;
    } es_ms_t;

endpackage

// ==== src/stage_if.sv ====
`timescale 1ns/1ps

// execute to memory stage handoff
interface stage_if import exe_pkg::*; ();
    logic   valid;
    logic   allowin;
    es_ms_t payload;

    modport src (
        output valid,
        output payload,
        input  allowin
    );

    modport dst (
        input  valid,
        input  payload,
        output allowin
    );
endinterface

// ==== src/dmem_if.sv ====
`timescale 1ns/1ps

interface dmem_if ();
    logic        req;
    logic        wr;      // 1 for store
    logic [31:0] addr;
    logic [3:0]  wstrb;
    logic [31:0] wdata;
    logic        addr_ok; // no response pending
    logic        data_ok; // one cycle after acceptance
    logic [31:0] rdata;

    modport master (
        output req, wr, addr, wstrb, wdata,
        input  addr_ok, data_ok, rdata
    );

    modport slave (
        input  req, wr, addr, wstrb, wdata,
        output addr_ok, data_ok, rdata
    );
endinterface

// ==== src/divider.sv ====
`timescale 1ns/1ps

module divider import exe_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        start,
    input  logic        signed_op,
    input  logic [31:0] dividend,
    input  logic [31:0] divisor,
    output logic [31:0] quotient,
    output logic        done
);
    logic        busy;
    logic [5:0]  cnt;
    logic [31:0] rem;
    logic [31:0] quo;       // dividend shifts out while quotient bits shift in
    logic [31:0] dvs;
    logic        neg;
    logic        zero_div;
    logic [32:0] shifted;
    logic [32:0] trial;

    assign shifted = {rem, quo[31]};
    assign trial   = shifted - {1'b0, dvs};

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            done <= 1'b0;
            cnt  <= '0;
        end else if (start) begin
            busy <= 1'b1;
            done <= 1'b0;   // level stays up until the next start
            cnt  <= '0;
        end else if (busy) begin
            cnt <= cnt + 6'd1;
            if (cnt == 6'(DIV_CYCLES - 2)) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            rem      <= '0;
            quo      <= (signed_op && dividend[31]) ? -dividend : dividend;
            dvs      <= (signed_op && divisor[31]) ? -divisor : divisor;
            neg      <= signed_op && (dividend[31] ^ divisor[31]);
            zero_div <= (divisor == 32'd0);
        end else if (busy) begin
            rem <= trial[32] ? shifted[31:0] : trial[31:0]; // restore on borrow
            quo <= {quo[30:0], ~trial[32]};
        end
    end

    assign quotient = zero_div ? 32'hffff_ffff : (neg ? -quo : quo);

    a_no_start_busy: assert property (@(posedge clk) disable iff (reset)
        start |-> !busy);

endmodule

// ==== src/alu.sv ====
`timescale 1ns/1ps

module alu import exe_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  op_t         op,
    input  logic        start,
    input  logic [31:0] src1,
    input  logic [31:0] src2,
    output logic [31:0] result,
    output logic        overflow,
    output logic        div_done
);
    logic        is_div;
    logic [31:0] sum;
    logic [31:0] diff;
    logic [4:0]  sa;
    logic [31:0] quotient;

    assign is_div = (op == op_div) || (op == op_divu);
    assign sum    = src1 + src2;
    assign diff   = src1 - src2;
    assign sa     = src1[4:0]; // shift amount from src1

    always_comb begin
        case (op)
            op_add, op_addu: result = sum;
            op_sub, op_subu: result = diff;
            op_and:  result = src1 & src2;
            op_or:   result = src1 | src2;
            op_xor:  result = src1 ^ src2;
            op_nor:  result = ~(src1 | src2);
            op_slt:  result = {31'b0, $signed(src1) < $signed(src2)};
            op_sltu: result = {31'b0, src1 < src2};
            op_sll:  result = src2 << sa;
            op_srl:  result = src2 >> sa;
            op_sra:  result = $unsigned($signed(src2) >>> sa);
            op_lui:  result = {src2[15:0], 16'b0};
            default: result = quotient; // div, divu
        endcase
    end

    // signed overflow only for the trapping forms
    always_comb begin
        case (op)
            op_add:  overflow = (src1[31] == src2[31]) && (sum[31] != src1[31]);
            op_sub:  overflow = (src1[31] != src2[31]) && (diff[31] != src1[31]);
            default: overflow = 1'b0;
        endcase
    end

    divider u_divider (
        .clk       (clk),
        .reset     (reset),
        .start     (start && is_div),
        .signed_op (op == op_div),
        .dividend  (src1),
        .divisor   (src2),
        .quotient  (quotient),
        .done      (div_done)
    );

endmodule

// ==== src/exe_stage.sv ====
`timescale 1ns/1ps

module exe_stage import exe_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        in_valid,
    output logic        in_ready,
    input  op_t         in_op,
    input  mem_op_t     in_mem_op,
    input  logic [31:0] in_src1,
    input  logic [31:0] in_src2,
    input  logic [31:0] in_store_data,
    input  logic [4:0]  in_dest,
    stage_if.src        ms,
    dmem_if.master      dmem
);
    logic        es_valid;
    logic        es_ready_go;
    logic        es_accept;
    op_t         es_op;
    mem_op_t     es_mem_op;
    logic [31:0] es_src1;
    logic [31:0] es_src2;
    logic [31:0] es_store_data;
    logic [4:0]  es_dest;
    logic        req_sent;  // request already accepted by the ram
    logic        mem_done;  // data_ok seen while stalled
    logic        div_sent;
    logic [31:0] rdata_r;
    logic        is_load;
    logic        is_store;
    logic        is_mem;
    logic        is_div;
    op_t         alu_op;
    logic [31:0] alu_result;
    logic        alu_overflow;
    logic        div_start;
    logic        div_done;
    logic        ades;
    logic        adel;
    exc_t        es_exc;
    es_ms_t      es_rec;

    assign is_load  = es_mem_op inside {mem_lb, mem_lbu, mem_lh, mem_lhu, mem_lw};
    assign is_store = es_mem_op inside {mem_sb, mem_sh, mem_sw};
    assign is_mem   = is_load || is_store;
    assign is_div   = !is_mem && (es_op == op_div || es_op == op_divu);

    assign alu_op    = is_mem ? op_addu : es_op; // address add
    assign div_start = es_valid && is_div && !div_sent;

    alu u_alu (
        .clk      (clk),
        .reset    (reset),
        .op       (alu_op),
        .start    (div_start),
        .src1     (es_src1),
        .src2     (es_src2),
        .result   (alu_result),
        .overflow (alu_overflow),
        .div_done (div_done)
    );

    assign ades = (es_mem_op == mem_sh && alu_result[0])
               || (es_mem_op == mem_sw && alu_result[1:0] != 2'b00);
    assign adel = ((es_mem_op == mem_lh || es_mem_op == mem_lhu) && alu_result[0])
               || (es_mem_op == mem_lw && alu_result[1:0] != 2'b00);
    assign es_exc = alu_overflow ? exc_ov : ades ? exc_ades : adel ? exc_adel : exc_none;

    always_comb begin
        if (is_mem && es_exc == exc_none)
            es_ready_go = dmem.data_ok || mem_done;
        else if (is_div)
            es_ready_go = div_sent && div_done;
        else
            es_ready_go = 1'b1; // faulting access leaves at once
    end

    assign in_ready  = !es_valid || (es_ready_go && ms.allowin);
    assign es_accept = in_valid && in_ready;
    assign ms.valid  = es_valid && es_ready_go;

    always_ff @(posedge clk) begin
        if (reset)
            es_valid <= 1'b0;
        else if (in_ready)
            es_valid <= in_valid;
    end

    always_ff @(posedge clk) begin
        if (es_accept) begin
            es_op         <= in_op;
            es_mem_op     <= in_mem_op;
            es_src1       <= in_src1;
            es_src2       <= in_src2;
            es_store_data <= in_store_data;
            es_dest       <= in_dest;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || es_accept) begin
            req_sent <= 1'b0;
            mem_done <= 1'b0;
            div_sent <= 1'b0;
        end else begin
            if (dmem.req && dmem.addr_ok)
                req_sent <= 1'b1;
            if (dmem.data_ok)
                mem_done <= 1'b1;
            if (div_start)
                div_sent <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (dmem.data_ok)
            rdata_r <= dmem.rdata;
    end

    // memory request
    assign dmem.req   = es_valid && is_mem && es_exc == exc_none && !req_sent;
    assign dmem.wr    = is_store;
    assign dmem.addr  = alu_result;

    always_comb begin
        case (es_mem_op)
            mem_sb: begin
                dmem.wstrb = 4'b0001 << alu_result[1:0];
                dmem.wdata = {4{es_store_data[7:0]}};
            end
            mem_sh: begin
                dmem.wstrb = alu_result[1] ? 4'b1100 : 4'b0011;
                dmem.wdata = {2{es_store_data[15:0]}};
            end
            mem_sw: begin
                dmem.wstrb = 4'b1111;
                dmem.wdata = es_store_data;
            end
            default: begin
                dmem.wstrb = 4'b0000;   // loads write nothing
                dmem.wdata = es_store_data;
            end
        endcase
    end

    always_comb begin
        es_rec.dest     = (es_exc == exc_none) ? es_dest : 5'd0;
        es_rec.result   = alu_result;
        es_rec.mem_op   = es_mem_op;
        es_rec.byte_sel = alu_result[1:0];
        es_rec.rdata    = dmem.data_ok ? dmem.rdata : rdata_r;
        es_rec.exc      = es_exc;
    end

    assign ms.payload = es_rec;

    // a faulting record never gets a response from the ram
    a_no_req_on_exc: assert property (@(posedge clk) disable iff (reset)
        es_valid && es_exc != exc_none |=> !dmem.data_ok);

endmodule

// ==== src/data_ram.sv ====
`timescale 1ns/1ps

module data_ram import exe_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    dmem_if.slave  bus
);
    logic [31:0]        mem [DMEM_WORDS];
    logic               pending;
    logic               accept;
    logic [DMEM_AW-1:0] idx;
    logic [31:0]        rdata_r;

    assign idx         = bus.addr[DMEM_AW+1:2]; // upper address bits wrap
    assign bus.addr_ok = !pending;
    assign accept      = bus.req && bus.addr_ok;

    always_ff @(posedge clk) begin
        if (reset)
            pending <= 1'b0;
        else
            pending <= accept;
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rdata_r <= mem[idx];    // old word even for stores
            for (int i = 0; i < 4; i++) begin
                if (bus.wr && bus.wstrb[i])
                    mem[idx][8*i +: 8] <= bus.wdata[8*i +: 8];
            end
        end
    end

    assign bus.data_ok = pending;
    assign bus.rdata   = rdata_r;

    a_single_data_ok: assert property (@(posedge clk) disable iff (reset)
        bus.data_ok |=> !bus.data_ok);

endmodule

// ==== src/mem_stage.sv ====
`timescale 1ns/1ps

module mem_stage import exe_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    stage_if.dst        es,
    output logic        out_valid,
    input  logic        out_ready,
    output logic [4:0]  out_dest,
    output logic [31:0] out_result,
    output exc_t        out_exc
);
    logic        ms_valid;
    es_ms_t      ms_rec;
    logic [7:0]  ld_byte;
    logic [15:0] ld_half;

    assign es.allowin = !ms_valid || out_ready;
    assign out_valid  = ms_valid;

    always_ff @(posedge clk) begin
        if (reset)
            ms_valid <= 1'b0;
        else if (es.allowin)
            ms_valid <= es.valid;
    end

    always_ff @(posedge clk) begin
        if (es.valid && es.allowin)
            ms_rec <= es.payload;
    end

    assign ld_byte = ms_rec.rdata[{ms_rec.byte_sel, 3'b000} +: 8];
    assign ld_half = ms_rec.byte_sel[1] ? ms_rec.rdata[31:16] : ms_rec.rdata[15:0];

    always_comb begin
        if (ms_rec.exc != exc_none)
            out_result = ms_rec.result; // faulting address
        else
            case (ms_rec.mem_op)
                mem_lb:  out_result = {{24{ld_byte[7]}}, ld_byte};
                mem_lbu: out_result = {24'b0, ld_byte};
                mem_lh:  out_result = {{16{ld_half[15]}}, ld_half};
                mem_lhu: out_result = {16'b0, ld_half};
                mem_lw:  out_result = ms_rec.rdata;
                default: out_result = ms_rec.result;
            endcase
    end

    assign out_dest = ms_rec.dest;
    assign out_exc  = ms_rec.exc;

    a_hold_on_stall: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_dest)
            && $stable(out_result) && $stable(out_exc));

endmodule

// ==== src/exe_top.sv ====
`timescale 1ns/1ps

module exe_top import exe_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        in_valid,
    output logic        in_ready,
    input  op_t         in_op,
    input  mem_op_t     in_mem_op,
    input  logic [31:0] in_src1,
    input  logic [31:0] in_src2,
    input  logic [31:0] in_store_data,
    input  logic [4:0]  in_dest,
    output logic        out_valid,
    input  logic        out_ready,
    output logic [4:0]  out_dest,
    output logic [31:0] out_result,
    output exc_t        out_exc
);
    stage_if es_ms ();
    dmem_if  dmem ();

    exe_stage u_exe_stage (
        .clk           (clk),
        .reset         (reset),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .in_op         (in_op),
        .in_mem_op     (in_mem_op),
        .in_src1       (in_src1),
        .in_src2       (in_src2),
        .in_store_data (in_store_data),
        .in_dest       (in_dest),
        .ms            (es_ms.src),
        .dmem          (dmem.master)
    );

    data_ram u_data_ram (
        .clk   (clk),
        .reset (reset),
        .bus   (dmem.slave)
    );

    mem_stage u_mem_stage (
        .clk        (clk),
        .reset      (reset),
        .es         (es_ms.dst),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_dest   (out_dest),
        .out_result (out_result),
        .out_exc    (out_exc)
    );

endmodule

// ==== dv/tb_checker.sv ====
`timescale 1ns/1ps

module tb_checker import exe_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  int          test_id,
    input  logic        in_valid,
    input  logic        in_ready,
    input  op_t         in_op,
    input  mem_op_t     in_mem_op,
    input  logic [31:0] in_src1,
    input  logic [31:0] in_src2,
    input  logic [31:0] in_store_data,
    input  logic [4:0]  in_dest,
    input  logic        out_valid,
    input  logic        out_ready,
    input  logic [4:0]  out_dest,
    input  logic [31:0] out_result,
    input  exc_t        out_exc,
    output int          pending,
    output int          total_checks,
    output int          total_errors
);
    typedef struct packed {
        logic [4:0]  dest;
        logic [31:0] result;
        exc_t        exc;
    } exp_t;

    exp_t        q[$];      // accepted but not yet seen at the output
    exp_t        want;
    logic [31:0] shadow [DMEM_WORDS];
    int          checks = 0;
    int          errors = 0;
    int          t_checks = 0;
    int          t_errors = 0;
    int          last_id = 0;

    function automatic string test_name(input int id);
        case (id)
            0: return "reset";
            1: return "alu";
            2: return "divide";
            3: return "load_store";
            4: return "faults";
            5: return "backpressure";
            default: return "end";
        endcase
    endfunction

    // magnitudes divided, sign applied afterwards
    function automatic logic [31:0] div_ref(input logic [31:0] a, input logic [31:0] b,
                                            input logic sgn);
        logic [31:0] ma;
        logic [31:0] mb;
        logic [31:0] q_mag;
        if (b == 32'd0)
            return 32'hffff_ffff;
        ma    = (sgn && a[31]) ? -a : a;
        mb    = (sgn && b[31]) ? -b : b;
        q_mag = ma / mb;
        return (sgn && (a[31] != b[31])) ? -q_mag : q_mag;
    endfunction

    function automatic logic [31:0] alu_ref(input op_t op, input logic [31:0] a,
                                            input logic [31:0] b);
        logic [4:0] sh;
        sh = a[4:0];
        case (op)
            op_add, op_addu: return a + b;
            op_sub, op_subu: return a - b;
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            op_nor:  return ~(a | b);
            op_slt:  return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
            op_sltu: return {31'b0, a < b};
            op_sll:  return b << sh;
            op_srl:  return b >> sh;
            op_sra:  return b[31] ? ~(~b >> sh) : b >> sh; // fill with sign
            op_lui:  return {b[15:0], 16'h0};
            op_div:  return div_ref(a, b, 1'b1);
            default: return div_ref(a, b, 1'b0);
        endcase
    endfunction

    function automatic exp_t ref_model(input op_t op, input mem_op_t mop,
                                       input logic [31:0] a, input logic [31:0] b,
                                       input logic [4:0] dest);
        exp_t        e;
        logic [31:0] ea;
        logic [31:0] w;
        logic [15:0] h;
        logic [7:0]  by;
        logic [32:0] wide;
        ea = a + b;
        w  = shadow[ea[DMEM_AW+1:2]];
        by = w[8*ea[1:0] +: 8];
        h  = ea[1] ? w[31:16] : w[15:0];
        e.dest = dest;
        e.exc  = exc_none;
        case (mop)
            mem_lb:   e.result = {{24{by[7]}}, by};
            mem_lbu:  e.result = {24'b0, by};
            mem_lh:   e.result = {{16{h[15]}}, h};
            mem_lhu:  e.result = {16'b0, h};
            mem_lw:   e.result = w;
            mem_none: e.result = alu_ref(op, a, b);
            default:  e.result = ea;   // stores show their address
        endcase
        if ((mop inside {mem_lh, mem_lhu} && ea[0]) || (mop == mem_lw && ea[1:0] != 2'b00))
            e.exc = exc_adel;
        if ((mop == mem_sh && ea[0]) || (mop == mem_sw && ea[1:0] != 2'b00))
            e.exc = exc_ades;
        if (mop == mem_none && (op == op_add || op == op_sub)) begin
            wide = (op == op_add) ? {a[31], a} + {b[31], b} : {a[31], a} - {b[31], b};
            if (wide[32] != wide[31])
                e.exc = exc_ov;
        end
        if (e.exc != exc_none) begin
            e.dest = 5'd0;
            if (mop != mem_none)
                e.result = ea;
        end
        return e;
    endfunction

    function automatic void store_shadow(input mem_op_t mop, input logic [31:0] ea,
                                         input logic [31:0] d);
        logic [DMEM_AW-1:0] i;
        i = ea[DMEM_AW+1:2];
        case (mop)
            mem_sb:  shadow[i][8*ea[1:0] +: 8] = d[7:0];
            mem_sh:  shadow[i][16*ea[1] +: 16] = d[15:0];
            mem_sw:  shadow[i] = d;
            default: ;
        endcase
    endfunction

    task automatic count_check(input logic ok);
        checks++;
        t_checks++;
        if (!ok) begin
            errors++;
            t_errors++;
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            q.delete();
        end else begin
            if (test_id == 0) begin
                count_check(out_valid === 1'b0 && in_ready === 1'b1);
                if (out_valid !== 1'b0 || in_ready !== 1'b1)
                    $display("FAIL %s: out_valid/in_ready expected 0/1, actual %b/%b",
                             test_name(test_id), out_valid, in_ready);
            end
            // outputs are popped before this edge's input is pushed
            if (out_valid && out_ready) begin
                if (q.size() == 0) begin
                    count_check(1'b0);
                    $display("ERROR %s: output transfer with no instruction outstanding",
                             test_name(test_id));
                end else begin
                    want = q.pop_front();
                    count_check(out_dest === want.dest && out_result === want.result
                                && out_exc === want.exc);
                    if (out_dest !== want.dest || out_result !== want.result
                        || out_exc !== want.exc) begin
                        $write("FAIL %s: expected dest=%0d result=%h exc=%0d, ",
                               test_name(test_id), want.dest, want.result, want.exc);
                        $display("actual dest=%0d result=%h exc=%0d",
                                 out_dest, out_result, out_exc);
                    end
                end
            end
            if (in_valid && in_ready) begin
                want = ref_model(in_op, in_mem_op, in_src1, in_src2, in_dest);
                if (want.exc == exc_none)
                    store_shadow(in_mem_op, in_src1 + in_src2, in_store_data);
                q.push_back(want);
            end
        end
        if (test_id != last_id) begin
            $display("test %s done: %0d checks, %0d errors", test_name(last_id),
                     t_checks, t_errors);
            t_checks = 0;
            t_errors = 0;
            last_id  = test_id;
        end
        pending      <= q.size();
        total_checks <= checks;
        total_errors <= errors;
    end

endmodule

// ==== dv/tb_top.sv ====
`timescale 1ns/1ps

module tb_top import exe_pkg::*; ();
    logic        clk;
    logic        reset;
    logic        in_valid;
    logic        in_ready;
    op_t         in_op;
    mem_op_t     in_mem_op;
    logic [31:0] in_src1;
    logic [31:0] in_src2;
    logic [31:0] in_store_data;
    logic [4:0]  in_dest;
    logic        out_valid;
    logic        out_ready = 1'b1;
    logic [4:0]  out_dest;
    logic [31:0] out_result;
    exc_t        out_exc;
    int          test_id;
    int          pending;
    int          total_checks;
    int          total_errors;
    logic        bp_en;         // random out_ready when set
    logic [31:0] stim_state;
    logic [31:0] bp_state = 32'hf6d3_58d9;
    op_t         op;
    mem_op_t     m;
    logic [31:0] a;
    logic [31:0] b;
    logic [3:0]  w;

    exe_top i_dut (.*);

    tb_checker u_checker (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            stim_state = lfsr_step(stim_state);
            r = {r[30:0], stim_state[0]};
        end
        return r;
    endfunction

    always @(posedge clk) begin
        bp_state  <= lfsr_step(bp_state);
        out_ready <= bp_en ? bp_state[0] : 1'b1;
    end

    task automatic timed_out(input string what);
        $display("timeout: no %s within the cycle limit", what);
        $display("Result: FAILED");
        $finish;
    endtask

    task automatic send(input op_t op_i, input mem_op_t mop, input logic [31:0] s1,
                        input logic [31:0] s2, input logic [31:0] sd);
        int n;
        in_valid      <= 1'b1;
        in_op         <= op_i;
        in_mem_op     <= mop;
        in_src1       <= s1;
        in_src2       <= s2;
        in_store_data <= sd;
        in_dest       <= 5'(rand_bits(5));
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!in_ready && n < 200);
        if (!in_ready)
            timed_out("in_ready");
    endtask

    // base keeps bits 9:0 clear, so the word index comes from the offset alone
    task automatic mem_access(input mem_op_t mop, input logic [3:0] word, input logic misalign);
        logic [1:0]  r;
        logic [1:0]  off;
        logic [31:0] base;
        logic [31:0] data;
        r    = 2'(rand_bits(2));
        base = {22'(rand_bits(22)), 10'b0};
        data = rand_bits(32);
        case (mop)
            mem_lh, mem_lhu, mem_sh: off = {r[1], misalign};
            mem_lw, mem_sw:          off = misalign ? ((r == 2'd0) ? 2'd3 : r) : 2'd0;
            default:                 off = r;
        endcase
        send(op_addu, mop, base, {26'b0, word, off}, data);
    endtask

    task automatic finish_test(input int next_id);
        int n;
        in_valid <= 1'b0;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (pending != 0 && n < 2000);
        if (pending != 0)
            timed_out("drain of outstanding results");
        else
            test_id <= next_id;
    endtask

    initial begin
        stim_state = 32'hf6d3_58d9;
        reset         <= 1'b1;
        in_valid      <= 1'b0;
        in_op         <= op_add;
        in_mem_op     <= mem_none;
        in_src1       <= '0;
        in_src2       <= '0;
        in_store_data <= '0;
        in_dest       <= '0;
        test_id       <= 0;
        bp_en         <= 1'b0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        repeat (3) @(posedge clk);  // idle while the reset state is watched
        finish_test(1);

        for (int i = 0; i < 200; i++) begin
            op = op_t'(4'(rand_bits(4) % 14));
            a  = rand_bits(32);
            b  = rand_bits(32);
            send(op, mem_none, a, b, 32'd0);
        end
        finish_test(2);

        for (int i = 0; i < 24; i++) begin
            a  = rand_bits(32);
            b  = rand_bits(32);
            b  = b >> rand_bits(5);    // spread of quotient sizes
            op = (rand_bits(1) != 0) ? op_div : op_divu;
            send(op, mem_none, a, b, 32'd0);
        end
        a = rand_bits(32);
        send(op_div, mem_none, a, 32'd0, 32'd0);
        send(op_divu, mem_none, a, 32'd0, 32'd0);
        send(op_div, mem_none, 32'h8000_0000, 32'hffff_ffff, 32'd0);
        send(op_divu, mem_none, 32'h8000_0000, 32'hffff_ffff, 32'd0);
        finish_test(3);

        for (int i = 0; i < 16; i++)
            mem_access(mem_sw, 4'(i), 1'b0);   // fill the word window first
        for (int i = 0; i < 120; i++) begin
            m = mem_op_t'(4'(rand_bits(3) + 1));
            w = 4'(rand_bits(4));
            mem_access(m, w, 1'b0);
        end
        finish_test(4);

        for (int i = 0; i < 12; i++) begin
            w = 4'(rand_bits(4));
            m = (rand_bits(1) != 0) ? mem_sh : mem_sw;
            mem_access(m, w, 1'b1);
            m = (rand_bits(1) != 0) ? mem_lw : ((rand_bits(1) != 0) ? mem_lh : mem_lhu);
            mem_access(m, w, 1'b1);
            mem_access(mem_lw, w, 1'b0);       // word must be untouched
        end
        send(op_add, mem_none, 32'h7fff_ffff, 32'd1, 32'd0);
        send(op_sub, mem_none, 32'h8000_0000, 32'd1, 32'd0);
        for (int i = 0; i < 16; i++) begin
            op = (rand_bits(1) != 0) ? op_add : op_sub;
            a  = rand_bits(32);
            b  = rand_bits(32);
            send(op, mem_none, a, b, 32'd0);
        end
        finish_test(5);

        bp_en <= 1'b1;
        for (int i = 0; i < 150; i++) begin
            if (rand_bits(1) != 0) begin
                m = mem_op_t'(4'(rand_bits(3) + 1));
                w = 4'(rand_bits(4));
                mem_access(m, w, 1'b0);
            end else begin
                op = op_t'(4'(rand_bits(4)));
                a  = rand_bits(32);
                b  = rand_bits(32);
                send(op, mem_none, a, b, 32'd0);
            end
        end
        finish_test(6);
        bp_en <= 1'b0;
        repeat (2) @(posedge clk);
        $display("checks: %0d, errors: %0d", total_checks, total_errors);
        if (total_errors == 0 && total_checks > 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

// ==== src.f ====
src/exe_pkg.sv
src/stage_if.sv
src/dmem_if.sv
src/divider.sv
src/alu.sv
src/exe_stage.sv
src/data_ram.sv
src/mem_stage.sv
src/exe_top.sv
dv/tb_checker.sv
dv/tb_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -f src.f --top-module tb_top -o tb_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "compile failed, see build.log"
    exit 1
fi
./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
if grep -q "Result: FAILED" sim.log; then
    exit 1
fi
exit 0
